// ==== source/sched_settings.svh ====
`ifndef SCHED_SETTINGS_SVH
`define SCHED_SETTINGS_SVH

// Sizes of the scheduler
`define SCHED_CORE_COUNT 4
`define SCHED_SLOT_COUNT 8
`define SCHED_IF_COUNT   2
`define SCHED_DATA_WIDTH 64

// Control message type codes
`define SCHED_MSG_TYPE_SLOT 0
`define SCHED_MSG_TYPE_INIT 3

`endif

// ==== source/sched_pkg.sv ====
`include "sched_settings.svh"

package sched_pkg;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0] core_id_t;

  // Slots are numbered from 1, so one extra bit
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;

  typedef logic [4:0] tag_t;

  // Core above tag, sent as tdest
  typedef logic [$bits(core_id_t)+$bits(tag_t)-1:0] dest_t;

  typedef logic [$clog2(`SCHED_IF_COUNT)-1:0] port_id_t;

  typedef logic [3:0] msg_type_t;

  // Type in the top nibble, slot value from bit 16
  typedef logic [35:0] ctrl_data_t;

  typedef enum logic [1:0] {
    stall,
    first,
    wait_desc,
    mid
  } port_state_t;

endpackage

// ==== source/desc_if.sv ====
`timescale 1ns/1ps

// Descriptor offer from the slot pool, taken by the port dispatcher
interface desc_if;

  logic                avail;
  sched_pkg::core_id_t core;
  sched_pkg::slot_t    slot;
  logic                pop;

  modport pool (
    output avail,
    output core,
    output slot,
    input  pop
  );

  modport dispatcher (
    input  avail,
    input  core,
    input  slot,
    output pop
  );

endinterface

// ==== source/slot_keeper.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module slot_keeper (
  input  logic             clk,
  input  logic             rst,
  input  logic             init_valid,
  input  sched_pkg::slot_t slot_in,
  input  logic             push,
  input  logic             pop,
  output sched_pkg::slot_t head,
  output sched_pkg::slot_t count
);

  localparam int PTR_W = $clog2(`SCHED_SLOT_COUNT);
  localparam sched_pkg::slot_t FULL = sched_pkg::slot_t'(`SCHED_SLOT_COUNT);

  sched_pkg::slot_t mem [`SCHED_SLOT_COUNT];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic             do_push;
  logic             do_pop;
  sched_pkg::slot_t init_count;

  assign do_pop     = pop && (count != '0);
  assign do_push    = push && (count != FULL);
  assign init_count = (slot_in > FULL) ? FULL : slot_in;
  assign head       = mem[rd_ptr];

  // Init fills the whole ring with 1..SLOT_COUNT, count limits the valid part
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
        mem[i] <= sched_pkg::slot_t'(i + 1);
      end
    end else if (do_push) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= init_count[PTR_W-1:0];
      count  <= init_count;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== source/slot_pool.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module slot_pool (
  input  logic                         clk,
  input  logic                         rst,
  input  sched_pkg::ctrl_data_t        ctrl_tdata,
  input  logic                         ctrl_tvalid,
  input  sched_pkg::core_id_t          ctrl_tuser,
  input  logic [`SCHED_CORE_COUNT-1:0] income_cores,
  desc_if.pool                         desc
);

  localparam int TYPE_W   = $bits(sched_pkg::msg_type_t);
  localparam int SLOT_W   = $bits(sched_pkg::slot_t);
  localparam int SLOT_LSB = 16;

  sched_pkg::msg_type_t         msg_type;
  logic [`SCHED_CORE_COUNT-1:0] init_v;
  logic [`SCHED_CORE_COUNT-1:0] push_v;
  logic [`SCHED_CORE_COUNT-1:0] keeper_pop;
  sched_pkg::slot_t             slot_r;
  sched_pkg::slot_t             head [`SCHED_CORE_COUNT];
  sched_pkg::slot_t             count [`SCHED_CORE_COUNT];
  sched_pkg::core_id_t          sel_core;
  sched_pkg::slot_t             sel_count;
  logic                         sel_valid;

  assign msg_type = ctrl_tdata[$bits(sched_pkg::ctrl_data_t)-1 -: TYPE_W];

  // Per-core strobes, registered for timing
  always_ff @(posedge clk) begin
    if (rst) begin
      init_v <= '0;
      push_v <= '0;
    end else begin
      for (int i = 0; i < `SCHED_CORE_COUNT; i++) begin
        init_v[i] <= ctrl_tvalid && (ctrl_tuser == sched_pkg::core_id_t'(i)) &&
                     (msg_type == sched_pkg::msg_type_t'(`SCHED_MSG_TYPE_INIT));
        push_v[i] <= ctrl_tvalid && (ctrl_tuser == sched_pkg::core_id_t'(i)) &&
                     (msg_type == sched_pkg::msg_type_t'(`SCHED_MSG_TYPE_SLOT));
      end
    end
  end

  // Slot value travels with the strobes
  always_ff @(posedge clk) begin
    slot_r <= ctrl_tdata[SLOT_LSB +: SLOT_W];
  end

  for (genvar c = 0; c < `SCHED_CORE_COUNT; c++) begin : g_keeper
    assign keeper_pop[c] = desc.pop && (sel_core == sched_pkg::core_id_t'(c));

    slot_keeper u_keeper (
      .clk        (clk),
      .rst        (rst),
      .init_valid (init_v[c]),
      .slot_in    (slot_r),
      .push       (push_v[c]),
      .pop        (keeper_pop[c]),
      .head       (head[c]),
      .count      (count[c])
    );
  end

  // Most free slots among enabled cores, lowest index wins a tie
  always_comb begin
    sel_valid = 1'b0;
    sel_core  = '0;
    sel_count = '0;
    for (int i = 0; i < `SCHED_CORE_COUNT; i++) begin
      if (income_cores[i] && (count[i] != '0) && (count[i] > sel_count)) begin
        sel_valid = 1'b1;
        sel_core  = sched_pkg::core_id_t'(i);
        sel_count = count[i];
      end
    end
  end

  assign desc.avail = sel_valid;
  assign desc.core  = sel_core;
  assign desc.slot  = head[sel_core];

endmodule

// ==== source/port_dispatcher.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module port_dispatcher (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic [`SCHED_IF_COUNT-1:0]                    rx_tvalid,
  input  logic [`SCHED_IF_COUNT-1:0]                    rx_tlast,
  output logic [`SCHED_IF_COUNT-1:0]                    rx_tready,
  output logic [`SCHED_IF_COUNT-1:0]                    data_tvalid,
  input  logic [`SCHED_IF_COUNT-1:0]                    data_tready,
  output sched_pkg::dest_t    [`SCHED_IF_COUNT-1:0]     data_tdest,
  output sched_pkg::port_id_t [`SCHED_IF_COUNT-1:0]     data_tuser,
  desc_if.dispatcher                                    desc
);

  sched_pkg::port_state_t       state [`SCHED_IF_COUNT];
  sched_pkg::dest_t             loaded_desc [`SCHED_IF_COUNT];
  sched_pkg::dest_t             cur_desc [`SCHED_IF_COUNT];
  logic [`SCHED_IF_COUNT-1:0]   not_stall;
  logic [`SCHED_IF_COUNT-1:0]   accept;
  logic [`SCHED_IF_COUNT-1:0]   accept_last;
  logic [`SCHED_IF_COUNT-1:0]   desc_req;
  logic [`SCHED_IF_COUNT-1:0]   grant;
  sched_pkg::port_id_t          last_grant;
  sched_pkg::port_id_t          grant_idx;
  logic                         grant_found;
  sched_pkg::dest_t             new_desc;

  assign new_desc = {desc.core, sched_pkg::tag_t'(desc.slot)};

  // Round robin, search starts after the last granted port
  always_comb begin
    int cand;
    grant_found = 1'b0;
    grant_idx   = last_grant;
    for (int k = 1; k <= `SCHED_IF_COUNT; k++) begin
      cand = (int'(last_grant) + k) % `SCHED_IF_COUNT;
      if (!grant_found && desc_req[cand]) begin
        grant_found = 1'b1;
        grant_idx   = sched_pkg::port_id_t'(cand);
      end
    end
  end

  assign desc.pop = desc.avail && grant_found;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_grant <= sched_pkg::port_id_t'(`SCHED_IF_COUNT - 1);
    end else if (desc.pop) begin
      last_grant <= grant_idx;
    end
  end

  for (genvar p = 0; p < `SCHED_IF_COUNT; p++) begin : g_port
    assign not_stall[p]   = (state[p] != sched_pkg::stall);
    assign rx_tready[p]   = data_tready[p] && not_stall[p];
    assign data_tvalid[p] = rx_tvalid[p] && not_stall[p];
    assign accept[p]      = rx_tvalid[p] && rx_tready[p];
    assign accept_last[p] = accept[p] && rx_tlast[p];
    assign grant[p]       = desc.pop && (grant_idx == sched_pkg::port_id_t'(p));

    // Ask for the next descriptor while stalled or while a packet streams
    assign desc_req[p] = (state[p] == sched_pkg::stall) ||
                         (state[p] == sched_pkg::wait_desc);

    assign data_tdest[p] = (state[p] == sched_pkg::first) ? loaded_desc[p] : cur_desc[p];
    assign data_tuser[p] = sched_pkg::port_id_t'(p);

    always_ff @(posedge clk) begin
      if (rst) begin
        state[p] <= sched_pkg::stall;
      end else begin
        case (state[p])
          sched_pkg::stall: begin
            if (grant[p]) begin
              state[p] <= sched_pkg::first;
            end
          end
          sched_pkg::first: begin
            if (accept_last[p]) begin
              state[p] <= sched_pkg::stall;
            end else if (accept[p]) begin
              state[p] <= sched_pkg::wait_desc;
            end
          end
          sched_pkg::wait_desc: begin
            if (grant[p] && accept_last[p]) begin
              state[p] <= sched_pkg::first;
            end else if (grant[p]) begin
              state[p] <= sched_pkg::mid;
            end else if (accept_last[p]) begin
              state[p] <= sched_pkg::stall;
            end
          end
          default: begin
            if (accept_last[p]) begin
              state[p] <= sched_pkg::first;
            end
          end
        endcase
      end
    end

    // Loaded holds the next packet's descriptor, current the one in flight
    always_ff @(posedge clk) begin
      if (grant[p]) begin
        loaded_desc[p] <= new_desc;
      end
      if ((state[p] == sched_pkg::first) && accept[p]) begin
        cur_desc[p] <= loaded_desc[p];
      end
    end
  end

endmodule

// ==== source/scheduler_top.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module scheduler_top (
  input  logic                                                    clk,
  input  logic                                                    rst,

  // Ethernet ingress
  input  logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0]            rx_tdata,
  input  logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH/8-1:0]          rx_tkeep,
  input  logic [`SCHED_IF_COUNT-1:0]                              rx_tvalid,
  input  logic [`SCHED_IF_COUNT-1:0]                              rx_tlast,
  output logic [`SCHED_IF_COUNT-1:0]                              rx_tready,

  // Streams to the cores
  output logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0]            data_tdata,
  output logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH/8-1:0]          data_tkeep,
  output logic [`SCHED_IF_COUNT-1:0]                              data_tvalid,
  output logic [`SCHED_IF_COUNT-1:0]                              data_tlast,
  input  logic [`SCHED_IF_COUNT-1:0]                              data_tready,
  output logic [`SCHED_IF_COUNT*$bits(sched_pkg::dest_t)-1:0]     data_tdest,
  output logic [`SCHED_IF_COUNT*$bits(sched_pkg::port_id_t)-1:0]  data_tuser,

  // Control messages from the cores
  input  sched_pkg::ctrl_data_t                                   ctrl_tdata,
  input  logic                                                    ctrl_tvalid,
  input  sched_pkg::core_id_t                                     ctrl_tuser,

  input  logic [`SCHED_CORE_COUNT-1:0]                            income_cores
);

  desc_if desc_bus ();

  slot_pool u_pool (
    .clk          (clk),
    .rst          (rst),
    .ctrl_tdata   (ctrl_tdata),
    .ctrl_tvalid  (ctrl_tvalid),
    .ctrl_tuser   (ctrl_tuser),
    .income_cores (income_cores),
    .desc         (desc_bus.pool)
  );

  port_dispatcher u_dispatcher (
    .clk          (clk),
    .rst          (rst),
    .rx_tvalid    (rx_tvalid),
    .rx_tlast     (rx_tlast),
    .rx_tready    (rx_tready),
    .data_tvalid  (data_tvalid),
    .data_tready  (data_tready),
    .data_tdest   (data_tdest),
    .data_tuser   (data_tuser),
    .desc         (desc_bus.dispatcher)
  );

  // Payload goes straight through, only the handshake is gated
  assign data_tdata = rx_tdata;
  assign data_tkeep = rx_tkeep;
  assign data_tlast = rx_tlast;

endmodule

// ==== verif/sched_properties.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module sched_properties (
  input logic                                      clk,
  input logic                                      rst,
  input logic                                      pop,
  input logic                                      avail,
  input sched_pkg::slot_t                          slot,
  input logic [`SCHED_IF_COUNT-1:0]                grant,
  input logic [`SCHED_IF_COUNT-1:0]                rx_tready,
  input logic [`SCHED_IF_COUNT-1:0]                accept,
  input logic [`SCHED_IF_COUNT-1:0]                rx_tlast,
  input sched_pkg::dest_t [`SCHED_IF_COUNT-1:0]    data_tdest
);

  int fail_count = 0;

  // Port is between the words of a packet
  logic [`SCHED_IF_COUNT-1:0] in_pkt;
  // Port holds a granted descriptor for its next packet
  logic [`SCHED_IF_COUNT-1:0] has_desc;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt   <= '0;
      has_desc <= '0;
    end else begin
      for (int p = 0; p < `SCHED_IF_COUNT; p++) begin
        if (accept[p]) begin
          in_pkt[p] <= !rx_tlast[p];
        end
        if (grant[p]) begin
          has_desc[p] <= 1'b1;
        end else if (accept[p] && !in_pkt[p]) begin
          has_desc[p] <= 1'b0;
        end
      end
    end
  end

  a_pop_avail: assert property (@(posedge clk) disable iff (rst)
    pop |-> avail && (slot != '0) && (slot <= sched_pkg::slot_t'(`SCHED_SLOT_COUNT)))
    else begin
      $error("descriptor popped while no valid one is offered");
      fail_count++;
    end

  for (genvar p = 0; p < `SCHED_IF_COUNT; p++) begin : g_port
    // Stalled means outside a packet with no descriptor held
    a_stall_ready: assert property (@(posedge clk) disable iff (rst)
      !in_pkt[p] && !has_desc[p] |-> !rx_tready[p])
      else begin
        $error("stalled port accepts rx words");
        fail_count++;
      end

    // Next word of the same packet keeps its destination
    a_dest_steady: assert property (@(posedge clk) disable iff (rst)
      accept[p] && !rx_tlast[p] |=> data_tdest[p] == $past(data_tdest[p]))
      else begin
        $error("tdest changed inside a packet");
        fail_count++;
      end
  end

endmodule

bind port_dispatcher sched_properties u_props (
  .clk        (clk),
  .rst        (rst),
  .pop        (desc.pop),
  .avail      (desc.avail),
  .slot       (desc.slot),
  .grant      (grant),
  .rx_tready  (rx_tready),
  .accept     (accept),
  .rx_tlast   (rx_tlast),
  .data_tdest (data_tdest)
);

// ==== verif/sched_checker.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module sched_checker (
  input logic                                                   clk,
  input logic                                                   rst,
  input logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0]           rx_tdata,
  input logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH/8-1:0]         rx_tkeep,
  input logic [`SCHED_IF_COUNT-1:0]                             rx_tvalid,
  input logic [`SCHED_IF_COUNT-1:0]                             rx_tlast,
  input logic [`SCHED_IF_COUNT-1:0]                             rx_tready,
  input logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH-1:0]           data_tdata,
  input logic [`SCHED_IF_COUNT*`SCHED_DATA_WIDTH/8-1:0]         data_tkeep,
  input logic [`SCHED_IF_COUNT-1:0]                             data_tvalid,
  input logic [`SCHED_IF_COUNT-1:0]                             data_tlast,
  input logic [`SCHED_IF_COUNT-1:0]                             data_tready,
  input logic [`SCHED_IF_COUNT*$bits(sched_pkg::dest_t)-1:0]    data_tdest,
  input logic [`SCHED_IF_COUNT*$bits(sched_pkg::port_id_t)-1:0] data_tuser,
  input sched_pkg::ctrl_data_t                                  ctrl_tdata,
  input logic                                                   ctrl_tvalid,
  input sched_pkg::core_id_t                                    ctrl_tuser,
  input logic [`SCHED_CORE_COUNT-1:0]                           income_cores,
  input logic                                                   avail,
  input logic                                                   pop,
  input sched_pkg::core_id_t                                    pop_core,
  input sched_pkg::slot_t                                       pop_slot
);

  localparam int NP = `SCHED_IF_COUNT;
  localparam int NC = `SCHED_CORE_COUNT;
  localparam int NS = `SCHED_SLOT_COUNT;
  localparam int DW = `SCHED_DATA_WIDTH;
  localparam int KW = DW / 8;
  localparam int DEW = $bits(sched_pkg::dest_t);
  localparam int UW = $bits(sched_pkg::port_id_t);

  int   error_count = 0;
  int   words_out [NP];
  bit   init_seen;
  bit   free [NC][NS+1];
  bit   reserved [NC][NS+1];
  bit   in_pkt [NP];
  // Control messages reach the counts two edges after they are sampled
  logic d1_v, d2_v;
  logic [3:0] d1_t, d2_t;
  int   d1_c, d2_c, d1_s, d2_s;

  initial begin
    for (int p = 0; p < NP; p++) begin
      words_out[p] = 0;
      in_pkt[p] = 0;
    end
  end

  function automatic int free_count(input int c);
    int n;
    n = 0;
    for (int s = 1; s <= NS; s++) begin
      if (free[c][s]) n++;
    end
    return n;
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic apply_msg(input logic [3:0] t, input int c, input int s);
    if (t == `SCHED_MSG_TYPE_INIT) begin
      for (int k = 0; k <= NS; k++) begin
        free[c][k] = (k >= 1) && (k <= s);
      end
    end else if ((t == `SCHED_MSG_TYPE_SLOT) && (s >= 1) && (s <= NS)) begin
      free[c][s] = 1'b1;
    end
  endtask

  task report_counts(input int other_errors, input int assert_errors);
    $display("Error count: %0d checker, %0d stream bookkeeping, %0d assertions",
             error_count, other_errors, assert_errors);
  endtask

  always @(posedge clk) begin
    int best;
    int core;
    int slot;
    sched_pkg::dest_t dest;
    if (rst) begin
      d1_v = 1'b0;
      d2_v = 1'b0;
    end else begin
      if (d2_v) apply_msg(d2_t, d2_c, d2_s);
      best = 0;
      for (int c = 0; c < NC; c++) begin
        if (income_cores[c] && free_count(c) > best) best = free_count(c);
      end
      if (avail !== (best != 0)) begin
        report_error($sformatf("avail is %0b, model expects %0b", avail, best != 0));
      end
      if (pop) begin
        if (!income_cores[pop_core]) begin
          report_error($sformatf("descriptor taken from disabled core %0d", pop_core));
        end
        if (free_count(pop_core) != best) begin
          report_error($sformatf("core %0d with %0d free slots chosen, best is %0d",
                                 pop_core, free_count(pop_core), best));
        end
        if (pop_slot < 1 || pop_slot > NS || !free[pop_core][pop_slot]) begin
          report_error($sformatf("slot %0d of core %0d is not free", pop_slot, pop_core));
        end else begin
          free[pop_core][pop_slot] = 1'b0;
          reserved[pop_core][pop_slot] = 1'b1;
        end
      end
      for (int p = 0; p < NP; p++) begin
        if (!init_seen && (rx_tready[p] || data_tvalid[p])) begin
          report_error($sformatf("port %0d active before any init", p));
        end
        if ((rx_tvalid[p] && rx_tready[p]) != (data_tvalid[p] && data_tready[p])) begin
          report_error($sformatf("port %0d rx and data handshakes differ", p));
        end
        if (data_tvalid[p] && data_tready[p]) begin
          words_out[p]++;
          if (data_tdata[p*DW +: DW] !== rx_tdata[p*DW +: DW] ||
              data_tkeep[p*KW +: KW] !== rx_tkeep[p*KW +: KW] ||
              data_tlast[p] !== rx_tlast[p]) begin
            report_error($sformatf("port %0d word %0d differs from rx", p, words_out[p]));
          end
          if (data_tuser[p*UW +: UW] != p) begin
            report_error($sformatf("port %0d tuser is %0d", p, data_tuser[p*UW +: UW]));
          end
          if (!in_pkt[p]) begin
            dest = data_tdest[p*DEW +: DEW];
            core = dest[DEW-1 -: 2];
            slot = dest[4:0];
            if (slot < 1 || slot > NS || !reserved[core][slot]) begin
              report_error($sformatf("port %0d packet sent to core %0d slot %0d not held",
                                     p, core, slot));
            end else begin
              reserved[core][slot] = 1'b0;
            end
          end
          in_pkt[p] = !data_tlast[p];
        end
      end
      d2_v = d1_v;
      d2_t = d1_t;
      d2_c = d1_c;
      d2_s = d1_s;
      d1_v = ctrl_tvalid;
      d1_t = ctrl_tdata[35:32];
      d1_c = ctrl_tuser;
      d1_s = ctrl_tdata[16 +: 4];
      if (ctrl_tvalid && ctrl_tdata[35:32] == `SCHED_MSG_TYPE_INIT) init_seen = 1'b1;
    end
  end

endmodule

// ==== verif/sched_tb.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module sched_tb;

  localparam int NP = `SCHED_IF_COUNT;
  localparam int DW = `SCHED_DATA_WIDTH;
  localparam int KW = DW / 8;
  localparam int DEW = $bits(sched_pkg::dest_t);
  localparam int PKTS = 120;
  localparam int LIMIT = 2000;

  logic clk;
  logic rst;
  logic [NP*DW-1:0] rx_tdata;
  logic [NP*KW-1:0] rx_tkeep;
  logic [NP-1:0] rx_tvalid, rx_tlast, rx_tready;
  logic [NP*DW-1:0] data_tdata;
  logic [NP*KW-1:0] data_tkeep;
  logic [NP-1:0] data_tvalid, data_tlast, data_tready;
  logic [NP*DEW-1:0] data_tdest;
  logic [NP*$bits(sched_pkg::port_id_t)-1:0] data_tuser;
  sched_pkg::ctrl_data_t ctrl_tdata;
  logic ctrl_tvalid;
  sched_pkg::core_id_t ctrl_tuser;
  logic [`SCHED_CORE_COUNT-1:0] income_cores;

  logic [31:0] rng [4];
  int cycle = 0;
  int tb_errors = 0;
  int sent_words [NP];
  sched_pkg::dest_t ret_dest [$];
  int ret_due [$];

  scheduler_top UUT (.*);

  sched_checker u_checker (
    .clk (clk), .rst (rst),
    .rx_tdata (rx_tdata), .rx_tkeep (rx_tkeep), .rx_tvalid (rx_tvalid),
    .rx_tlast (rx_tlast), .rx_tready (rx_tready),
    .data_tdata (data_tdata), .data_tkeep (data_tkeep), .data_tvalid (data_tvalid),
    .data_tlast (data_tlast), .data_tready (data_tready),
    .data_tdest (data_tdest), .data_tuser (data_tuser),
    .ctrl_tdata (ctrl_tdata), .ctrl_tvalid (ctrl_tvalid), .ctrl_tuser (ctrl_tuser),
    .income_cores (income_cores),
    .avail (UUT.desc_bus.avail), .pop (UUT.desc_bus.pop),
    .pop_core (UUT.desc_bus.core), .pop_slot (UUT.desc_bus.slot)
  );

  // One LCG state per stimulus stream keeps the streams independent
  function automatic logic [31:0] rand_next(input int s);
    rng[s] = rng[s] * 32'd1103515245 + 32'd12345;
    return rng[s] >> 8;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timeout: no progress while waiting for %s", what);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic drive_ctrl(input int msg_type, input int core, input int slot);
    ctrl_tdata = '0;
    ctrl_tdata[35:32] = msg_type;
    ctrl_tdata[16 +: 4] = slot;
    ctrl_tuser = core;
    ctrl_tvalid = 1'b1;
  endtask

  task automatic run_port(input int p);
    int len;
    int gap;
    int waited;
    bit accepted;
    for (int n = 0; n < PKTS; n++) begin
      len = rand_next(p) % 6 + 1;
      for (int w = 0; w < len; w++) begin
        rx_tdata[p*DW +: DW] = {rand_next(p), rand_next(p)};
        rx_tkeep[p*KW +: KW] = (w == len - 1) ? (8'hff >> (rand_next(p) % 8)) : 8'hff;
        rx_tlast[p] = (w == len - 1);
        rx_tvalid[p] = 1'b1;
        waited = 0;
        accepted = 0;
        while (!accepted && waited < LIMIT) begin
          @(posedge clk);
          accepted = rx_tvalid[p] && rx_tready[p];
          waited++;
        end
        if (!accepted) stop_on_timeout($sformatf("port %0d to accept a word", p));
        sent_words[p]++;
        #10;
      end
      rx_tvalid[p] = 1'b0;
      gap = rand_next(p) % 3;
      repeat (gap) begin
        @(posedge clk);
        #10;
      end
    end
  endtask

  // Sends the inits and later the slot returns
  // The pause in returns uses up every slot
  task automatic control_loop;
    int init_slots [4] = '{8, 6, 7, 5};
    sched_pkg::dest_t d;
    repeat (6) begin
      @(posedge clk);
      #10;
    end
    for (int c = 0; c < `SCHED_CORE_COUNT; c++) begin
      drive_ctrl(`SCHED_MSG_TYPE_INIT, c, init_slots[c]);
      @(posedge clk);
      #10;
    end
    ctrl_tvalid = 1'b0;
    forever begin
      @(posedge clk);
      #10;
      if (cycle == 700) income_cores[3] = 1'b0;
      if (ret_dest.size() > 0 && cycle >= ret_due[0] && !(cycle >= 150 && cycle < 450)) begin
        d = ret_dest.pop_front();
        void'(ret_due.pop_front());
        drive_ctrl(`SCHED_MSG_TYPE_SLOT, d[DEW-1 -: 2], d[3:0]);
      end else begin
        ctrl_tvalid = 1'b0;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!rst) begin
      for (int p = 0; p < NP; p++) begin
        if (data_tvalid[p] && data_tready[p] && data_tlast[p]) begin
          ret_dest.push_back(data_tdest[p*DEW +: DEW]);
          ret_due.push_back(cycle + 3 + rand_next(3) % 12);
        end
      end
    end
  end

  always @(posedge clk) begin
    #10;
    for (int p = 0; p < NP; p++) begin
      data_tready[p] = rst ? 1'b0 : (rand_next(2) % 4 != 0);
    end
  end

  initial begin
    int waited;
    int assert_errors;
    rng[0] = 32'd2987;
    for (int i = 1; i < 4; i++) rng[i] = rng[i-1] * 32'd1103515245 + 32'd12345;
    rst = 1'b1;
    rx_tdata = '0;
    rx_tkeep = '0;
    rx_tvalid = '0;
    rx_tlast = '0;
    data_tready = '0;
    ctrl_tdata = '0;
    ctrl_tvalid = 1'b0;
    ctrl_tuser = '0;
    income_cores = '1;
    sent_words = '{default: 0};
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;
    fork
      control_loop();
    join_none
    fork
      run_port(0);
      run_port(1);
    join
    waited = 0;
    while ((ret_dest.size() != 0 || ctrl_tvalid) && waited < LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (ret_dest.size() != 0 || ctrl_tvalid) stop_on_timeout("slot returns to drain");
    repeat (4) @(posedge clk);
    for (int p = 0; p < NP; p++) begin
      if (sent_words[p] != u_checker.words_out[p]) begin
        $display("error at %0t: port %0d sent %0d words but %0d arrived", $time, p,
                 sent_words[p], u_checker.words_out[p]);
        tb_errors++;
      end
    end
    assert_errors = UUT.u_dispatcher.u_props.fail_count;
    u_checker.report_counts(tb_errors, assert_errors);
    if (u_checker.error_count + tb_errors + assert_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+source
source/sched_pkg.sv
source/desc_if.sv
source/slot_keeper.sv
source/slot_pool.sv
source/port_dispatcher.sv
source/scheduler_top.sv
verif/sched_properties.sv
verif/sched_checker.sv
verif/sched_tb.sv
